/* rtl/stereo_geom_pkg.sv */
package stereo_geom_pkg;

	////////////////////
	// field widths
	////////////////////

	localparam int PIX_W = 8;         // greyscale depth
	localparam int COORD_W = 9;       // row or col index, up to 511
	localparam int ADDR_W = 17;       // image memory, 384 x 288 fits
	localparam int RESULT_ADDR_W = 19; // result memory address

	////////////////////
	// default geometry
	////////////////////

	localparam int DEF_WIDTH = 384;   // pixels per row
	localparam int DEF_HEIGHT = 288;  // rows per image

	////////////////////
	// types
	////////////////////

	typedef logic [PIX_W-1:0] pixel_t;                 // one image sample
	typedef logic [COORD_W-1:0] coord_t;               // row / col counter
	typedef logic [ADDR_W-1:0] addr_t;                 // left / right memory address
	typedef logic [RESULT_ADDR_W-1:0] result_addr_t;   // row * width + col

endpackage

/* rtl/match_pkg.sv */
package match_pkg;

	////////////////////
	// field widths
	////////////////////

	localparam int DISP_W = 6;   // up to 63 candidates per pixel
	localparam int COST_W = 14;  // plain SAD sum, no division

	////////////////////
	// default search
	////////////////////

	localparam int DEF_MAX_DISP = 20;   // candidates 0 .. 19
	localparam int DEF_HALF_BLOCK = 3;  // 7 x 7 block

	////////////////////
	// types
	////////////////////

	// candidate shift, also the value written to the result memory
	typedef logic [DISP_W-1:0] disp_t;

	// block cost; the arg-min compares these directly
	typedef logic [COST_W-1:0] cost_t;

endpackage

/* rtl/match_if.sv */
`timescale 1ns/1ps

////////////////////
// pixel pair stream
////////////////////

// one left / right pixel pair per valid cycle, block order
interface pixel_pair_if;
	logic valid;                        // pair present this cycle
	stereo_geom_pkg::pixel_t left_pix;  // template block pixel, zero outside image
	stereo_geom_pkg::pixel_t right_pix; // shifted block pixel, zero outside image
	logic last;                         // final pair of the candidate block

	modport src (output valid, output left_pix, output right_pix, output last);
	modport dst (input valid, input left_pix, input right_pix, input last);
endinterface

////////////////////
// candidate costs
////////////////////

// one strobe per candidate disparity
interface cost_if;
	logic valid;              // cost present this cycle
	match_pkg::cost_t cost;   // SAD over the whole block
	match_pkg::disp_t disp;   // candidate the cost belongs to
	logic last_cand;          // final candidate of this pixel

	modport src (output valid, output cost, output disp, output last_cand);
	modport dst (input valid, input cost, input disp, input last_cand);
endinterface

/* rtl/pixel_fetch.sv */
`timescale 1ns/1ps

module pixel_fetch #(
	parameter int IMG_WIDTH = stereo_geom_pkg::DEF_WIDTH,
	parameter int IMG_HEIGHT = stereo_geom_pkg::DEF_HEIGHT,
	parameter int MAX_DISP = match_pkg::DEF_MAX_DISP,
	parameter int HALF_BLOCK = match_pkg::DEF_HALF_BLOCK
) (
	input  logic clk,
	input  logic reset,
	input  logic start,
	input  stereo_geom_pkg::pixel_t left_data,   // one cycle after left_addr
	input  stereo_geom_pkg::pixel_t right_data,  // one cycle after right_addr
	input  logic scan_done,                      // final result written
	output stereo_geom_pkg::addr_t left_addr,
	output stereo_geom_pkg::addr_t right_addr,
	output logic busy,
	pixel_pair_if.src pair,
	output match_pkg::disp_t cand_disp,          // tag for the block ending on pair.last
	output logic cand_last                       // that block is the pixel's last candidate
);

	localparam int BLOCK = 2 * HALF_BLOCK + 1;

	////////////////////
	// scan state
	////////////////////

	logic run;                         // issuing addresses
	stereo_geom_pkg::coord_t row, col; // centre pixel
	match_pkg::disp_t cand;            // current candidate
	logic [3:0] brow, bcol;            // position inside block

	stereo_geom_pkg::coord_t room;     // columns left of the right edge
	match_pkg::disp_t cand_lim;        // last candidate for this pixel

	logic signed [10:0] blk_y, blk_xl, blk_xr; // block pixel coordinates
	logic left_ok, right_ok;           // coordinate lies inside image
	logic left_ok_d, right_ok_d;       // aligned with returned data

	logic blk_end, cand_end, col_end, row_end;

	// candidate range clipped where the shifted block leaves the image
	assign room = stereo_geom_pkg::coord_t'(IMG_WIDTH - 1) - col;
	assign cand_lim = (room < stereo_geom_pkg::coord_t'(MAX_DISP - 1)) ?
		match_pkg::disp_t'(room) : match_pkg::disp_t'(MAX_DISP - 1);

	assign blk_end = (bcol == 4'(BLOCK - 1)) && (brow == 4'(BLOCK - 1));
	assign cand_end = blk_end && (cand == cand_lim);
	assign col_end = (col == stereo_geom_pkg::coord_t'(IMG_WIDTH - 1));
	assign row_end = (row == stereo_geom_pkg::coord_t'(IMG_HEIGHT - 1));

	////////////////////
	// address stage
	////////////////////

	assign blk_y = 11'(row) + 11'(brow) - 11'(HALF_BLOCK);
	assign blk_xl = 11'(col) + 11'(bcol) - 11'(HALF_BLOCK);
	assign blk_xr = blk_xl + 11'(cand); // right block shifted by d

	assign left_ok = !blk_y[10] && (blk_y < 11'(IMG_HEIGHT)) &&
		!blk_xl[10] && (blk_xl < 11'(IMG_WIDTH));
	assign right_ok = !blk_y[10] && (blk_y < 11'(IMG_HEIGHT)) &&
		!blk_xr[10] && (blk_xr < 11'(IMG_WIDTH));

	// out of image reads go to 0, the data is dropped later anyway
	assign left_addr = left_ok ?
		stereo_geom_pkg::addr_t'(blk_y) * stereo_geom_pkg::addr_t'(IMG_WIDTH) +
		stereo_geom_pkg::addr_t'(blk_xl) : '0;
	assign right_addr = right_ok ?
		stereo_geom_pkg::addr_t'(blk_y) * stereo_geom_pkg::addr_t'(IMG_WIDTH) +
		stereo_geom_pkg::addr_t'(blk_xr) : '0;

	// nested counters, bcol fastest, row slowest
	always_ff @(posedge clk) begin
		if (reset) begin
			run <= 1'b0;
			busy <= 1'b0;
			row <= '0;
			col <= '0;
			cand <= '0;
			brow <= '0;
			bcol <= '0;
		end else if (start && !busy) begin
			run <= 1'b1;
			busy <= 1'b1;
			row <= '0;
			col <= '0;
			cand <= '0;
			brow <= '0;
			bcol <= '0;
		end else begin
			if (scan_done)
				busy <= 1'b0; // last result is out
			if (run) begin
				if (bcol != 4'(BLOCK - 1)) begin
					bcol <= bcol + 4'd1;
				end else begin
					bcol <= '0;
					if (!blk_end) begin
						brow <= brow + 4'd1;
					end else begin
						brow <= '0;
						if (!cand_end) begin
							cand <= cand + 1'b1;
						end else begin
							cand <= '0;
							if (!col_end) begin
								col <= col + 1'b1;
							end else begin
								col <= '0;
								if (!row_end)
									row <= row + 1'b1;
								else
									run <= 1'b0; // final pair issued
							end
						end
					end
				end
			end
		end
	end

	////////////////////
	// data return stage
	////////////////////

	always_ff @(posedge clk) begin
		if (reset) begin
			pair.valid <= 1'b0;
		end else begin
			pair.valid <= run; // memory latency of one
		end
	end

	// sideband follows the pair through the memory cycle
	always_ff @(posedge clk) begin
		pair.last <= run && blk_end;
		left_ok_d <= left_ok;
		right_ok_d <= right_ok;
		cand_disp <= cand;
		cand_last <= cand_end;
	end

	// zero padding
	assign pair.left_pix = left_ok_d ? left_data : '0;
	assign pair.right_pix = right_ok_d ? right_data : '0;

endmodule

/* rtl/sad_accumulate.sv */
`timescale 1ns/1ps

module sad_accumulate (
	input  logic clk,
	input  logic reset,
	pixel_pair_if.dst pair,
	input  match_pkg::disp_t cand_disp,  // valid with pair.last
	input  logic cand_last,              // valid with pair.last
	cost_if.src cost
);

	stereo_geom_pkg::pixel_t abs_diff;   // |left - right|
	match_pkg::cost_t acc;               // running block sum
	match_pkg::cost_t acc_next;

	assign abs_diff = (pair.left_pix > pair.right_pix) ?
		pair.left_pix - pair.right_pix :
		pair.right_pix - pair.left_pix;

	assign acc_next = acc + match_pkg::cost_t'(abs_diff);

	////////////////////
	// accumulate
	////////////////////

	always_ff @(posedge clk) begin
		if (reset) begin
			acc <= '0;
			cost.valid <= 1'b0;
		end else begin
			cost.valid <= pair.valid && pair.last; // one per candidate
			if (pair.valid) begin
				if (pair.last)
					acc <= '0; // next block starts clean
				else
					acc <= acc_next;
			end
		end
	end

	// total and tag, registered with the strobe
	always_ff @(posedge clk) begin
		if (pair.valid && pair.last) begin
			cost.cost <= acc_next;
			cost.disp <= cand_disp;
			cost.last_cand <= cand_last;
		end
	end

endmodule

/* rtl/disparity_select.sv */
`timescale 1ns/1ps

module disparity_select #(
	parameter int IMG_WIDTH = stereo_geom_pkg::DEF_WIDTH,
	parameter int IMG_HEIGHT = stereo_geom_pkg::DEF_HEIGHT
) (
	input  logic clk,
	input  logic reset,
	cost_if.dst cost,
	output stereo_geom_pkg::result_addr_t result_addr,
	output match_pkg::disp_t result_data,
	output logic result_we,
	output logic done,
	output logic scan_done   // final write in progress
);

	localparam stereo_geom_pkg::result_addr_t LAST_ADDR =
		stereo_geom_pkg::result_addr_t'(IMG_WIDTH * IMG_HEIGHT - 1);

	match_pkg::cost_t best_cost;          // minimum so far for this pixel
	match_pkg::disp_t best_disp;          // its disparity
	logic take;                           // new cost replaces the minimum
	match_pkg::disp_t pick_disp;          // winner including this candidate
	stereo_geom_pkg::result_addr_t pix_addr; // raster position of current pixel
	logic result_final;                   // current write is the last pixel

	// strict compare keeps the smallest d on ties, d = 0 always seeds
	assign take = (cost.disp == '0) || (cost.cost < best_cost);
	assign pick_disp = take ? cost.disp : best_disp;

	assign scan_done = result_we && result_final;

	////////////////////
	// running minimum
	////////////////////

	always_ff @(posedge clk) begin
		if (cost.valid && take) begin
			best_cost <= cost.cost;
			best_disp <= cost.disp;
		end
		if (cost.valid && cost.last_cand) begin
			result_data <= pick_disp;
			result_addr <= pix_addr;
			result_final <= (pix_addr == LAST_ADDR);
		end
	end

	////////////////////
	// write and done
	////////////////////

	always_ff @(posedge clk) begin
		if (reset) begin
			result_we <= 1'b0;
			done <= 1'b0;
			pix_addr <= '0;
		end else begin
			result_we <= cost.valid && cost.last_cand;
			done <= scan_done; // one cycle after final write
			if (cost.valid && cost.last_cand) begin
				if (pix_addr == LAST_ADDR)
					pix_addr <= '0; // ready for the next frame
				else
					pix_addr <= pix_addr + 1'b1;
			end
		end
	end

endmodule

/* rtl/disparity_top.sv */
`timescale 1ns/1ps

module disparity_top #(
	parameter int IMG_WIDTH = stereo_geom_pkg::DEF_WIDTH,
	parameter int IMG_HEIGHT = stereo_geom_pkg::DEF_HEIGHT,
	parameter int MAX_DISP = match_pkg::DEF_MAX_DISP,
	parameter int HALF_BLOCK = match_pkg::DEF_HALF_BLOCK
) (
	input  logic clk,
	input  logic reset,
	input  logic start,                          // ignored while busy
	input  stereo_geom_pkg::pixel_t left_data,
	input  stereo_geom_pkg::pixel_t right_data,
	output stereo_geom_pkg::addr_t left_addr,
	output stereo_geom_pkg::addr_t right_addr,
	output stereo_geom_pkg::result_addr_t result_addr,
	output match_pkg::disp_t result_data,
	output logic result_we,
	output logic busy,
	output logic done
);

	pixel_pair_if pair_bus ();   // fetch -> accumulate
	cost_if cost_bus ();         // accumulate -> select

	match_pkg::disp_t cand_disp;
	logic cand_last;
	logic scan_done;             // select tells fetch the map is complete

	pixel_fetch #(
		.IMG_WIDTH(IMG_WIDTH),
		.IMG_HEIGHT(IMG_HEIGHT),
		.MAX_DISP(MAX_DISP),
		.HALF_BLOCK(HALF_BLOCK)
	) u_pixel_fetch (
		.clk(clk),
		.reset(reset),
		.start(start),
		.left_data(left_data),
		.right_data(right_data),
		.scan_done(scan_done),
		.left_addr(left_addr),
		.right_addr(right_addr),
		.busy(busy),
		.pair(pair_bus.src),
		.cand_disp(cand_disp),
		.cand_last(cand_last)
	);

	sad_accumulate u_sad_accumulate (
		.clk(clk),
		.reset(reset),
		.pair(pair_bus.dst),
		.cand_disp(cand_disp),
		.cand_last(cand_last),
		.cost(cost_bus.src)
	);

	disparity_select #(
		.IMG_WIDTH(IMG_WIDTH),
		.IMG_HEIGHT(IMG_HEIGHT)
	) u_disparity_select (
		.clk(clk),
		.reset(reset),
		.cost(cost_bus.dst),
		.result_addr(result_addr),
		.result_data(result_data),
		.result_we(result_we),
		.done(done),
		.scan_done(scan_done)
	);

endmodule

/* verif/disparity_checker.sv */
`timescale 1ns/1ps

module disparity_checker #(
	parameter int IMG_WIDTH = stereo_geom_pkg::DEF_WIDTH,
	parameter int IMG_HEIGHT = stereo_geom_pkg::DEF_HEIGHT
) (
	input logic clk,
	input logic reset,
	input logic result_we,
	input logic busy,
	input logic done,
	input stereo_geom_pkg::result_addr_t result_addr
);

	localparam int AREA = IMG_WIDTH * IMG_HEIGHT; // one result per pixel

	////////////////////
	// result writes
	////////////////////

	write_in_scan: assert property (@(posedge clk) disable iff (reset)
		result_we |-> busy) // busy drops only after final write
		else $error("result write outside busy");

	write_in_range: assert property (@(posedge clk) disable iff (reset)
		result_we |-> (result_addr < stereo_geom_pkg::result_addr_t'(AREA)))
		else $error("result address beyond image area");

	////////////////////
	// completion
	////////////////////

	done_single: assert property (@(posedge clk) disable iff (reset)
		done |=> !done) // single pulse
		else $error("done longer than one cycle");

	done_idle: assert property (@(posedge clk) disable iff (reset)
		done |-> !busy) // busy falls together with done
		else $error("busy still high with done");

endmodule

bind disparity_top disparity_checker #(
	.IMG_WIDTH(IMG_WIDTH),
	.IMG_HEIGHT(IMG_HEIGHT)
) u_disparity_checker (
	.clk(clk),
	.reset(reset),
	.result_we(result_we),
	.busy(busy),
	.done(done),
	.result_addr(result_addr)
);

/* verif/tb_disparity.sv */
`timescale 1ns/1ps

module tb_disparity;

	localparam int IMG_WIDTH = 16;
	localparam int IMG_HEIGHT = 8;
	localparam int MAX_DISP = 4;
	localparam int HALF_BLOCK = 1;
	localparam int NPIX = IMG_WIDTH * IMG_HEIGHT;
	localparam int TIMEOUT = 20000;        // cycles allowed for a map of about 4200

	logic clk, reset, start;
	stereo_geom_pkg::pixel_t left_data, right_data;
	stereo_geom_pkg::addr_t left_addr, right_addr;
	stereo_geom_pkg::addr_t left_addr_q, right_addr_q; // address of last cycle
	stereo_geom_pkg::result_addr_t result_addr;
	match_pkg::disp_t result_data;
	logic result_we, busy, done, done_q;

	stereo_geom_pkg::pixel_t left_mem [NPIX];  // left image
	stereo_geom_pkg::pixel_t right_mem [NPIX]; // right image
	stereo_geom_pkg::result_addr_t wr_addr [$]; // writes in arrival order
	match_pkg::disp_t wr_data [$];
	int err_count, fail_count, test_count;
	bit hung;                                  // a map never finished

	disparity_top #(
		.IMG_WIDTH(IMG_WIDTH),
		.IMG_HEIGHT(IMG_HEIGHT),
		.MAX_DISP(MAX_DISP),
		.HALF_BLOCK(HALF_BLOCK)
	) u_disparity_top (
		.clk(clk),
		.reset(reset),
		.start(start),
		.left_data(left_data),
		.right_data(right_data),
		.left_addr(left_addr),
		.right_addr(right_addr),
		.result_addr(result_addr),
		.result_data(result_data),
		.result_we(result_we),
		.busy(busy),
		.done(done)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	// block memories return data for last cycle's address
	always @(negedge clk) begin
		left_data = (left_addr_q < NPIX) ? left_mem[left_addr_q] : '0;
		right_data = (right_addr_q < NPIX) ? right_mem[right_addr_q] : '0;
		left_addr_q = left_addr;
		right_addr_q = right_addr;
	end

	// result memory capture at mid cycle
	always @(negedge clk) begin
		if (!reset && result_we) begin
			wr_addr.push_back(result_addr);
			wr_data.push_back(result_data);
			if (!busy)
				report_error("result write while busy is low");
		end
		if (done && done_q)
			report_error("done stayed high for more than one cycle");
		done_q = done;
	end

	////////////////////
	// checks
	////////////////////

	task automatic report_error(input string msg);
		err_count++;
		$display("error at %0t: %s", $time, msg);
	endtask

	task automatic compare_disp(input string name, input match_pkg::disp_t got,
		input match_pkg::disp_t exp);
		if (got !== exp) begin
			err_count++;
			$display("mismatch %s: got 0x%h, expected 0x%h", name, got, exp);
		end
	endtask

	task automatic compare_addr(input string name, input stereo_geom_pkg::result_addr_t got,
		input stereo_geom_pkg::result_addr_t exp);
		if (got !== exp) begin
			err_count++;
			$display("mismatch %s: got 0x%h, expected 0x%h", name, got, exp);
		end
	endtask

	task automatic compare_flag(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			err_count++;
			$display("mismatch %s: got 0x%h, expected 0x%h", name, got, exp);
		end
	endtask

	////////////////////
	// reference model
	////////////////////

	// zero outside the image
	function automatic int sample(input bit from_right, input int r, input int c);
		if (r < 0 || r >= IMG_HEIGHT || c < 0 || c >= IMG_WIDTH)
			return 0;
		if (from_right)
			return int'(right_mem[r * IMG_WIDTH + c]);
		return int'(left_mem[r * IMG_WIDTH + c]);
	endfunction

	function automatic match_pkg::disp_t expected_disp(input int r, input int c);
		int d_top, cost, best_cost, best_d, diff;
		d_top = MAX_DISP - 1;
		if (IMG_WIDTH - 1 - c < d_top)
			d_top = IMG_WIDTH - 1 - c;      // clipped at right edge
		best_cost = -1;
		best_d = 0;
		for (int d = 0; d <= d_top; d++) begin
			cost = 0;
			for (int dy = -HALF_BLOCK; dy <= HALF_BLOCK; dy++) begin
				for (int dx = -HALF_BLOCK; dx <= HALF_BLOCK; dx++) begin
					diff = sample(0, r + dy, c + dx) - sample(1, r + dy, c + dx + d);
					cost += (diff < 0) ? -diff : diff;
				end
			end
			if (best_cost < 0 || cost < best_cost) begin // ties keep smaller d
				best_cost = cost;
				best_d = d;
			end
		end
		return match_pkg::disp_t'(best_d);
	endfunction

	////////////////////
	// run helpers
	////////////////////

	task automatic fill_random();
		for (int i = 0; i < NPIX; i++) begin
			left_mem[i] = stereo_geom_pkg::pixel_t'($urandom);
			right_mem[i] = stereo_geom_pkg::pixel_t'($urandom);
		end
	endtask

	// pulse start, wait for done
	task automatic run_map();
		int cycles;
		wr_addr.delete();
		wr_data.delete();
		@(negedge clk);
		start = 1'b1;
		@(negedge clk);
		start = 1'b0;
		compare_flag("busy", busy, 1'b1);
		cycles = 0;
		while (!done && cycles < TIMEOUT) begin
			@(negedge clk);
			cycles++;
		end
		if (!done) begin
			hung = 1'b1;
			report_error($sformatf("done did not arrive within %0d cycles", TIMEOUT));
		end else begin
			compare_flag("busy", busy, 1'b0);
		end
	endtask

	// every address once, raster order, values from the model or all zero
	task automatic check_map(input bit zero_map);
		match_pkg::disp_t exp;
		if (wr_addr.size() != NPIX)
			report_error($sformatf("expected %0d result writes, saw %0d", NPIX, wr_addr.size()));
		for (int i = 0; i < wr_addr.size() && i < NPIX; i++) begin
			exp = zero_map ? '0 : expected_disp(i / IMG_WIDTH, i % IMG_WIDTH);
			compare_addr($sformatf("result_addr[%0d]", i), wr_addr[i],
				stereo_geom_pkg::result_addr_t'(i));
			compare_disp($sformatf("result_data[%0d]", i), wr_data[i], exp);
		end
	endtask

	task automatic finish_test(input string name, input int errs_before);
		test_count++;
		if (err_count != errs_before) begin
			fail_count++;
			$display("test %s: failed with %0d errors", name, err_count - errs_before);
		end else begin
			$display("test %s: passed", name);
		end
	endtask

	////////////////////
	// directed tests
	////////////////////

	task automatic idle_after_reset();
		int errs;
		errs = err_count;
		for (int i = 0; i < 20; i++) begin
			@(negedge clk);
			compare_flag("result_we", result_we, 1'b0);
			compare_flag("done", done, 1'b0);
			compare_flag("busy", busy, 1'b0);
		end
		finish_test("reset_idle", errs);
	endtask

	task automatic constant_images();
		int errs;
		stereo_geom_pkg::pixel_t level;
		errs = err_count;
		level = stereo_geom_pkg::pixel_t'($urandom);
		for (int i = 0; i < NPIX; i++) begin
			left_mem[i] = level;
			right_mem[i] = level;
		end
		run_map();
		if (!hung)
			check_map(1'b1);
		finish_test("constant_images", errs);
	endtask

	task automatic shifted_image();
		int errs;
		errs = err_count;
		fill_random();
		for (int i = 0; i < NPIX; i++) begin
			if (i % IMG_WIDTH >= 2)
				right_mem[i] = left_mem[i - 2]; // scene moved two columns right
		end
		run_map();
		if (!hung)
			check_map(1'b0);
		finish_test("shifted_image", errs);
	endtask

	task automatic random_images();
		int errs;
		errs = err_count;
		fill_random();
		run_map();
		if (!hung)
			check_map(1'b0);
		finish_test("random_images", errs);
	endtask

	task automatic restart_after_done();
		int errs;
		errs = err_count;
		fill_random();
		run_map();
		if (!hung) begin
			check_map(1'b0);
			run_map();                           // same images as a second frame
		end
		if (!hung)
			check_map(1'b0);
		finish_test("repeat_start", errs);
	endtask

	initial begin
		void'($urandom(45));
		reset = 1'b1;
		start = 1'b0;
		left_data = '0;
		right_data = '0;
		left_addr_q = '0;
		right_addr_q = '0;
		done_q = 1'b0;
		err_count = 0;
		fail_count = 0;
		test_count = 0;
		hung = 1'b0;
		repeat (8) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;
		idle_after_reset();
		if (!hung)
			constant_images();
		if (!hung)
			shifted_image();
		if (!hung)
			random_images();
		if (!hung)
			restart_after_done();
		$display("summary: %0d tests run, %0d failed, %0d errors", test_count, fail_count,
			err_count);
		if (err_count == 0 && !hung)
			$display("** PASS **");
		else
			$display("** FAIL **");
		$finish;
	end

endmodule

/* list.f */
rtl/stereo_geom_pkg.sv
rtl/match_pkg.sv
rtl/match_if.sv
rtl/pixel_fetch.sv
rtl/sad_accumulate.sv
rtl/disparity_select.sv
rtl/disparity_top.sv
verif/disparity_checker.sv
verif/tb_disparity.sv

/* run.sh */
#!/bin/sh
# build the disparity testbench with Verilator, run it, grep the log
cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
	--top-module tb_disparity --Mdir "$BUILD_DIR" -o sim_tb \
	-f list.f
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

"./$BUILD_DIR/sim_tb" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -qF '** PASS **' "$LOG"; then
	echo "run.sh: simulation passed"
	exit 0
fi
echo "run.sh: simulation failed"
exit 1
